// File: Makefile
# Verilator build and run for the decode stage testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_decode_stage
FILELIST = mips_decode.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: include/mips_decode_defs.svh
// widths and MIPS encoding numbers for the decode stage
// include wherever a width, opcode or funct number is needed
`ifndef MIPS_DECODE_DEFS_SVH
`define MIPS_DECODE_DEFS_SVH

// ====================
// widths
// ====================
`define MD_XLEN      32
`define MD_REG_AW    5
`define MD_NREGS     32
`define MD_LINK_REG  5'd31

// ====================
// opcodes
// ====================
`define MD_OP_RTYPE  6'h00
`define MD_OP_REGIMM 6'h01
`define MD_OP_J      6'h02
`define MD_OP_JAL    6'h03
`define MD_OP_BEQ    6'h04
`define MD_OP_BNE    6'h05
`define MD_OP_BLEZ   6'h06
`define MD_OP_BGTZ   6'h07
`define MD_OP_ADDI   6'h08
`define MD_OP_ADDIU  6'h09
`define MD_OP_SLTI   6'h0a
`define MD_OP_SLTIU  6'h0b
`define MD_OP_ANDI   6'h0c
`define MD_OP_ORI    6'h0d
`define MD_OP_XORI   6'h0e
`define MD_OP_LUI    6'h0f
`define MD_OP_LB     6'h20
`define MD_OP_LH     6'h21
`define MD_OP_LW     6'h23
`define MD_OP_LBU    6'h24
`define MD_OP_LHU    6'h25
`define MD_OP_SW     6'h2b

// ====================
// funct codes
// ====================
`define MD_FN_SLL    6'h00
`define MD_FN_SRL    6'h02
`define MD_FN_SRA    6'h03
`define MD_FN_JR     6'h08
`define MD_FN_JALR   6'h09
`define MD_FN_ADD    6'h20
`define MD_FN_ADDU   6'h21
`define MD_FN_SUB    6'h22
`define MD_FN_SUBU   6'h23
`define MD_FN_AND    6'h24
`define MD_FN_OR     6'h25
`define MD_FN_XOR    6'h26
`define MD_FN_NOR    6'h27
`define MD_FN_SLT    6'h2a
`define MD_FN_SLTU   6'h2b

`endif

// File: mips_decode.f
+incdir+include
src/decode_pkg.sv
src/main_control.sv
src/branch_jump_control.sv
src/branch_compare.sv
src/register_bank.sv
src/target_gen.sv
src/decode_stage.sv
tests/tb_clock_gen.sv
tests/tb_decode_stage.sv

// File: src/branch_compare.sv
// early branch resolution on the register bank outputs
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module branch_compare (
	input  logic [`MD_XLEN-1:0]    i_rs_data,
	input  logic [`MD_XLEN-1:0]    i_rt_data,
	input  decode_pkg::branch_op_t i_branch_op,
	output logic                   o_taken
);
	import decode_pkg::*;

	logic equal;
	logic rs_zero;
	logic rs_neg;

	assign equal   = (i_rs_data == i_rt_data);
	assign rs_zero = (i_rs_data == '0);
	// sign bit, all zero compares are signed
	assign rs_neg  = i_rs_data[`MD_XLEN-1];

	always_comb begin
		case (i_branch_op)
			BR_EQ:   o_taken = equal;
			BR_NE:   o_taken = !equal;
			BR_LEZ:  o_taken = rs_neg || rs_zero;
			BR_GTZ:  o_taken = !rs_neg && !rs_zero;
			BR_LTZ:  o_taken = rs_neg;
			BR_GEZ:  o_taken = !rs_neg;
			default: o_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/branch_jump_control.sv
// branch condition and jump kind decoder
// resolves REGIMM forms with instruction bit 16
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module branch_jump_control (
	input  logic [5:0]             i_opcode,
	input  logic [5:0]             i_funct,
	input  logic                   i_regimm_gez,
	output decode_pkg::branch_op_t o_branch_op,
	output decode_pkg::jump_sel_t  o_jump_sel,
	output logic                   o_link
);
	import decode_pkg::*;

	always_comb begin
		o_branch_op = BR_NONE;
		o_jump_sel  = JUMP_NONE;
		o_link      = 1'b0;

		case (i_opcode)
			`MD_OP_BEQ:  o_branch_op = BR_EQ;
			`MD_OP_BNE:  o_branch_op = BR_NE;
			`MD_OP_BLEZ: o_branch_op = BR_LEZ;
			`MD_OP_BGTZ: o_branch_op = BR_GTZ;
			// bltz when bit 16 clear, bgez when set
			`MD_OP_REGIMM: o_branch_op = i_regimm_gez ? BR_GEZ : BR_LTZ;
			`MD_OP_J: o_jump_sel = JUMP_DIRECT;
			`MD_OP_JAL: begin
				o_jump_sel = JUMP_DIRECT;
				o_link     = 1'b1;
			end
			`MD_OP_RTYPE: begin
				if (i_funct == `MD_FN_JR) begin
					o_jump_sel = JUMP_REG;
				end else if (i_funct == `MD_FN_JALR) begin
					o_jump_sel = JUMP_REG;
					o_link     = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: src/decode_pkg.sv
// control encodings passed between the decoders, the stage top and execute
// import into any block that drives or reads these controls
`default_nettype none

package decode_pkg;

	// ====================
	// execute operation
	// ====================
	// immediate codes reuse the opcode number, execute decodes funct on ALU_RTYPE
	typedef enum logic [5:0] {
		ALU_RTYPE = 6'h00,
		ALU_ADDI  = 6'h08,
		ALU_ADDIU = 6'h09,
		ALU_SLTI  = 6'h0a,
		ALU_SLTIU = 6'h0b,
		ALU_ANDI  = 6'h0c,
		ALU_ORI   = 6'h0d,
		ALU_XORI  = 6'h0e,
		ALU_LUI   = 6'h0f,
		// address add for loads and stores
		ALU_ADDR  = 6'h20
	} alu_op_t;

	// load width for writeback
	// lhu and lbu share the half and byte codes, unsigned comes from ext mode
	typedef enum logic [1:0] {
		LD_WORD = 2'd0,
		LD_HALF = 2'd1,
		LD_BYTE = 2'd2
	} load_sel_t;

	// ====================
	// branch and jump
	// ====================
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4,
		BR_LTZ  = 3'd5,
		BR_GEZ  = 3'd6
	} branch_op_t;

	typedef enum logic [1:0] {
		JUMP_NONE   = 2'd0,
		JUMP_DIRECT = 2'd1,
		JUMP_REG    = 2'd2
	} jump_sel_t;

	// immediate extension
	typedef enum logic [1:0] {
		EXT_SIGN  = 2'd0,
		EXT_ZERO  = 2'd1,
		// lui, immediate into the upper half
		EXT_UPPER = 2'd2
	} ext_mode_t;

endpackage

`default_nettype wire

// File: src/decode_stage.sv
// instruction decode stage, reads registers, decodes controls, resolves branches
// early branch and jump outputs are same cycle, execute fields are registered
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module decode_stage (
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  logic                   i_instr_valid,
	input  logic [`MD_XLEN-1:0]    i_instr,
	input  logic [`MD_XLEN-1:0]    i_pc4,
	input  logic                   i_wb_we,
	input  logic [`MD_REG_AW-1:0]  i_wb_addr,
	input  logic [`MD_XLEN-1:0]    i_wb_data,
	output logic                   o_valid,
	output logic [`MD_XLEN-1:0]    o_rs_data,
	output logic [`MD_XLEN-1:0]    o_rt_data,
	output logic [`MD_XLEN-1:0]    o_imm_ext,
	output logic [`MD_XLEN-1:0]    o_pc4,
	output logic [`MD_REG_AW-1:0]  o_rs_addr,
	output logic [`MD_REG_AW-1:0]  o_rt_addr,
	output logic [`MD_REG_AW-1:0]  o_rd_addr,
	output decode_pkg::alu_op_t    o_alu_op,
	output logic                   o_alu_src,
	output logic                   o_reg_dst,
	output logic                   o_link,
	output logic                   o_mem_read,
	output logic                   o_mem_write,
	output logic                   o_mem_to_reg,
	output logic                   o_reg_write,
	output decode_pkg::load_sel_t  o_load_sel,
	output logic                   o_branch_taken,
	output decode_pkg::jump_sel_t  o_jump_sel,
	output logic [`MD_XLEN-1:0]    o_branch_target,
	output logic [`MD_XLEN-1:0]    o_jump_target
);
	import decode_pkg::*;

	// ====================
	// instruction fields
	// ====================
	logic [5:0]            opcode;
	logic [5:0]            funct;
	logic [`MD_REG_AW-1:0] rs_addr;
	logic [`MD_REG_AW-1:0] rt_addr;
	logic [`MD_REG_AW-1:0] rd_addr;

	assign opcode  = i_instr[31:26];
	assign rs_addr = i_instr[25:21];
	assign rt_addr = i_instr[20:16];
	assign funct   = i_instr[5:0];

	// decoded, not yet registered
	alu_op_t             alu_op;
	logic                alu_src, reg_dst, mem_read, mem_write, mem_to_reg, reg_write;
	load_sel_t           load_sel;
	ext_mode_t           ext_mode;
	branch_op_t          branch_op;
	jump_sel_t           jump_sel;
	logic                link;
	logic                taken;
	logic [`MD_XLEN-1:0] rs_data, rt_data, imm_ext;

	// jal writes r31, jalr keeps its rd field
	assign rd_addr = (jump_sel == JUMP_DIRECT && link) ? `MD_LINK_REG : i_instr[15:11];

	// ====================
	// blocks
	// ====================
	main_control u_main_control (
		.i_opcode(opcode), .o_alu_op(alu_op), .o_alu_src(alu_src),
		.o_reg_dst(reg_dst), .o_mem_read(mem_read), .o_mem_write(mem_write),
		.o_mem_to_reg(mem_to_reg), .o_reg_write(reg_write),
		.o_load_sel(load_sel), .o_ext_mode(ext_mode)
	);

	branch_jump_control u_branch_jump_control (
		.i_opcode(opcode), .i_funct(funct), .i_regimm_gez(i_instr[16]),
		.o_branch_op(branch_op), .o_jump_sel(jump_sel), .o_link(link)
	);

	register_bank u_register_bank (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_rs_addr(rs_addr), .i_rt_addr(rt_addr), .i_wr_addr(i_wb_addr),
		.i_we(i_wb_we), .i_wr_data(i_wb_data),
		.o_rs_data(rs_data), .o_rt_data(rt_data)
	);

	branch_compare u_branch_compare (
		.i_rs_data(rs_data), .i_rt_data(rt_data),
		.i_branch_op(branch_op), .o_taken(taken)
	);

	target_gen u_target_gen (
		.i_imm(i_instr[15:0]), .i_jidx(i_instr[25:0]), .i_pc4(i_pc4),
		.i_rs_data(rs_data), .i_ext_mode(ext_mode), .i_jump_sel(jump_sel),
		.o_imm_ext(imm_ext), .o_branch_target(o_branch_target),
		.o_jump_target(o_jump_target)
	);

	// early redirect, quiet without a strobe
	assign o_branch_taken = i_instr_valid && taken;
	assign o_jump_sel     = i_instr_valid ? jump_sel : JUMP_NONE;

	// ====================
	// decode to execute register
	// ====================
	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			o_valid      <= 1'b0;
			o_mem_read   <= 1'b0;
			o_mem_write  <= 1'b0;
			o_reg_write  <= 1'b0;
			o_rs_data    <= '0;
			o_rt_data    <= '0;
			o_imm_ext    <= '0;
			o_pc4        <= '0;
			o_rs_addr    <= '0;
			o_rt_addr    <= '0;
			o_rd_addr    <= '0;
			o_alu_op     <= ALU_RTYPE;
			o_alu_src    <= 1'b0;
			o_reg_dst    <= 1'b0;
			o_link       <= 1'b0;
			o_mem_to_reg <= 1'b0;
			o_load_sel   <= LD_WORD;
		end else begin
			// bubble drops the side effects
			o_valid      <= i_instr_valid;
			o_mem_read   <= i_instr_valid && mem_read;
			o_mem_write  <= i_instr_valid && mem_write;
			o_reg_write  <= i_instr_valid && reg_write;
			o_rs_data    <= rs_data;
			o_rt_data    <= rt_data;
			o_imm_ext    <= imm_ext;
			o_pc4        <= i_pc4;
			o_rs_addr    <= rs_addr;
			o_rt_addr    <= rt_addr;
			o_rd_addr    <= rd_addr;
			o_alu_op     <= alu_op;
			o_alu_src    <= alu_src;
			o_reg_dst    <= reg_dst;
			o_link       <= link;
			o_mem_to_reg <= mem_to_reg;
			o_load_sel   <= load_sel;
		end
	end

endmodule

`default_nettype wire

// File: src/main_control.sv
// main opcode decoder for execute, memory and writeback controls
// purely combinational, fed from the opcode field in the stage top
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module main_control (
	input  logic [5:0]            i_opcode,
	output decode_pkg::alu_op_t   o_alu_op,
	output logic                  o_alu_src,
	output logic                  o_reg_dst,
	output logic                  o_mem_read,
	output logic                  o_mem_write,
	output logic                  o_mem_to_reg,
	output logic                  o_reg_write,
	output decode_pkg::load_sel_t o_load_sel,
	output decode_pkg::ext_mode_t o_ext_mode
);
	import decode_pkg::*;

	always_comb begin
		// no-op defaults, all write enables low
		o_alu_op     = ALU_RTYPE;
		o_alu_src    = 1'b0;
		o_reg_dst    = 1'b0;
		o_mem_read   = 1'b0;
		o_mem_write  = 1'b0;
		o_mem_to_reg = 1'b0;
		o_reg_write  = 1'b0;
		o_load_sel   = LD_WORD;
		o_ext_mode   = EXT_SIGN;

		case (i_opcode)
			// also covers jr and jalr
			`MD_OP_RTYPE: begin
				o_reg_dst   = 1'b1;
				o_reg_write = 1'b1;
			end
			`MD_OP_ADDI, `MD_OP_ADDIU, `MD_OP_SLTI, `MD_OP_SLTIU: begin
				o_alu_op    = alu_op_t'(i_opcode);
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
			end
			`MD_OP_ANDI, `MD_OP_ORI, `MD_OP_XORI: begin
				o_alu_op    = alu_op_t'(i_opcode);
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
				o_ext_mode  = EXT_ZERO;
			end
			`MD_OP_LUI: begin
				o_alu_op    = ALU_LUI;
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
				o_ext_mode  = EXT_UPPER;
			end
			`MD_OP_LW, `MD_OP_LH, `MD_OP_LHU, `MD_OP_LB, `MD_OP_LBU: begin
				o_alu_op     = ALU_ADDR;
				o_alu_src    = 1'b1;
				o_mem_read   = 1'b1;
				o_mem_to_reg = 1'b1;
				o_reg_write  = 1'b1;
				if (i_opcode == `MD_OP_LH || i_opcode == `MD_OP_LHU)
					o_load_sel = LD_HALF;
				else if (i_opcode == `MD_OP_LB || i_opcode == `MD_OP_LBU)
					o_load_sel = LD_BYTE;
				if (i_opcode == `MD_OP_LHU || i_opcode == `MD_OP_LBU)
					o_ext_mode = EXT_ZERO;
			end
			`MD_OP_SW: begin
				o_alu_op    = ALU_ADDR;
				o_alu_src   = 1'b1;
				o_mem_write = 1'b1;
			end
			// link into r31, the stage top forces the rd field
			`MD_OP_JAL: begin
				o_reg_dst   = 1'b1;
				o_reg_write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: src/register_bank.sv
// 32 x 32 register file, two async read ports and one write port
// writes land on the rising edge, same-cycle reads see the new value
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module register_bank (
	input  logic                  i_clk,
	input  logic                  i_nrst,
	input  logic [`MD_REG_AW-1:0] i_rs_addr,
	input  logic [`MD_REG_AW-1:0] i_rt_addr,
	input  logic [`MD_REG_AW-1:0] i_wr_addr,
	input  logic                  i_we,
	input  logic [`MD_XLEN-1:0]   i_wr_data,
	output logic [`MD_XLEN-1:0]   o_rs_data,
	output logic [`MD_XLEN-1:0]   o_rt_data
);

	logic [`MD_XLEN-1:0] regs [`MD_NREGS];
	logic                wr_en;

	// r0 never written
	assign wr_en = i_we && (i_wr_addr != '0);

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			for (int i = 0; i < `MD_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// read port with write-through bypass
	function automatic logic [`MD_XLEN-1:0] read_port(input logic [`MD_REG_AW-1:0] addr);
		logic [`MD_XLEN-1:0] data;
		if (addr == '0)
			data = '0;
		else if (wr_en && (addr == i_wr_addr))
			data = i_wr_data;
		else
			data = regs[addr];
		return data;
	endfunction

	always_comb begin
		o_rs_data = read_port(i_rs_addr);
		o_rt_data = read_port(i_rt_addr);
	end

endmodule

`default_nettype wire

// File: src/target_gen.sv
// immediate extension plus branch and jump target forming
// combinational, uses pc4 of the instruction in decode
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module target_gen (
	input  logic [15:0]           i_imm,
	input  logic [25:0]           i_jidx,
	input  logic [`MD_XLEN-1:0]   i_pc4,
	input  logic [`MD_XLEN-1:0]   i_rs_data,
	input  decode_pkg::ext_mode_t i_ext_mode,
	input  decode_pkg::jump_sel_t i_jump_sel,
	output logic [`MD_XLEN-1:0]   o_imm_ext,
	output logic [`MD_XLEN-1:0]   o_branch_target,
	output logic [`MD_XLEN-1:0]   o_jump_target
);
	import decode_pkg::*;

	logic [`MD_XLEN-1:0] imm_sext;
	logic [`MD_XLEN-1:0] direct_target;

	assign imm_sext = {{(`MD_XLEN-16){i_imm[15]}}, i_imm};

	// ====================
	// immediate
	// ====================
	always_comb begin
		case (i_ext_mode)
			EXT_ZERO:  o_imm_ext = {{(`MD_XLEN-16){1'b0}}, i_imm};
			EXT_UPPER: o_imm_ext = {i_imm, 16'h0000};
			default:   o_imm_ext = imm_sext;
		endcase
	end

	// ====================
	// targets
	// ====================
	// word offset relative to the delay slot address
	assign o_branch_target = i_pc4 + {imm_sext[`MD_XLEN-3:0], 2'b00};

	// region of pc4 plus word index
	assign direct_target = {i_pc4[`MD_XLEN-1:`MD_XLEN-4], i_jidx, 2'b00};

	assign o_jump_target = (i_jump_sel == JUMP_REG) ? i_rs_data : direct_target;

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// clock and reset source for the decode stage testbench
// free running clock, active low reset released after a few rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 10,
	parameter int RST_CYCLES     = 3
) (
	output logic o_clk,
	output logic o_nrst
);

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD_NS o_clk = ~o_clk;
	end

	// release just after an edge, like the other stimulus
	initial begin
		o_nrst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_nrst = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/tb_decode_stage.sv
// testbench for the decode stage
// drives instructions and writebacks, checks outputs against its own decode rules
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_defs.svh"

module tb_decode_stage;
	import decode_pkg::*;

	localparam int wait_limit = 16;

	localparam logic [5:0] imm_ops [14] = '{
		`MD_OP_ADDI, `MD_OP_ADDIU, `MD_OP_SLTI, `MD_OP_SLTIU, `MD_OP_ANDI, `MD_OP_ORI,
		`MD_OP_XORI, `MD_OP_LUI, `MD_OP_LW, `MD_OP_LH, `MD_OP_LHU, `MD_OP_LB, `MD_OP_LBU,
		`MD_OP_SW
	};
	localparam logic [5:0] r_functs [13] = '{
		`MD_FN_ADD, `MD_FN_ADDU, `MD_FN_SUB, `MD_FN_SUBU, `MD_FN_AND, `MD_FN_OR, `MD_FN_XOR,
		`MD_FN_NOR, `MD_FN_SLT, `MD_FN_SLTU, `MD_FN_SLL, `MD_FN_SRL, `MD_FN_SRA
	};
	// last two are bltz and bgez, told apart by bit 16
	localparam logic [5:0] branch_ops [6] = '{
		`MD_OP_BEQ, `MD_OP_BNE, `MD_OP_BLEZ, `MD_OP_BGTZ, `MD_OP_REGIMM, `MD_OP_REGIMM
	};
	// lw, sw, beq r0 r0 and j, left on the bus while the strobe is low
	localparam logic [31:0] idle_instrs [4] = '{
		{`MD_OP_LW, 5'd2, 5'd1, 16'h0010},
		{`MD_OP_SW, 5'd2, 5'd1, 16'h0020},
		{`MD_OP_BEQ, 5'd0, 5'd0, 16'h0004},
		{`MD_OP_J, 26'h0000100}
	};

	logic                  clk;
	logic                  nrst;
	logic                  instr_valid;
	logic                  wb_we;
	logic [`MD_XLEN-1:0]   instr;
	logic [`MD_XLEN-1:0]   pc4;
	logic [`MD_XLEN-1:0]   wb_data;
	logic [`MD_REG_AW-1:0] wb_addr;
	logic                  valid, alu_src, reg_dst, link;
	logic                  mem_read, mem_write, mem_to_reg, reg_write;
	logic                  branch_taken;
	logic [`MD_XLEN-1:0]   rs_data, rt_data, imm_ext, pc4_q;
	logic [`MD_XLEN-1:0]   branch_target, jump_target;
	logic [`MD_REG_AW-1:0] rs_addr, rt_addr, rd_addr;
	alu_op_t               alu_op;
	load_sel_t             load_sel;
	jump_sel_t             jump_sel;

	// expected register contents
	logic [`MD_XLEN-1:0]   model_regs [`MD_NREGS];

	tb_clock_gen u_clock_gen (
		.o_clk(clk),
		.o_nrst(nrst)
	);

	decode_stage u_decode_stage (
		.i_clk(clk), .i_nrst(nrst), .i_instr_valid(instr_valid),
		.i_instr(instr), .i_pc4(pc4),
		.i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
		.o_valid(valid), .o_rs_data(rs_data), .o_rt_data(rt_data),
		.o_imm_ext(imm_ext), .o_pc4(pc4_q),
		.o_rs_addr(rs_addr), .o_rt_addr(rt_addr), .o_rd_addr(rd_addr),
		.o_alu_op(alu_op), .o_alu_src(alu_src), .o_reg_dst(reg_dst), .o_link(link),
		.o_mem_read(mem_read), .o_mem_write(mem_write),
		.o_mem_to_reg(mem_to_reg), .o_reg_write(reg_write), .o_load_sel(load_sel),
		.o_branch_taken(branch_taken), .o_jump_sel(jump_sel),
		.o_branch_target(branch_target), .o_jump_target(jump_target)
	);

	// ====================
	// failure handling
	// ====================
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic mismatch(input string msg);
		stop_run($sformatf("[ERROR] %0d ns: %s", $time, msg));
	endtask

	// strobe low for two cycles, with an optional writeback in the first
	task automatic bubble(input logic [31:0] ins, input logic we,
		input logic [`MD_REG_AW-1:0] waddr, input logic [`MD_XLEN-1:0] wdata);
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr       = ins;
		wb_we       = we;
		wb_addr     = waddr;
		wb_data     = wdata;
		if (we && waddr != '0)
			model_regs[waddr] = wdata;
		@(negedge clk);
		assert (!branch_taken && jump_sel === JUMP_NONE)
			else mismatch($sformatf("early redirect active without a strobe for %h", ins));
		@(posedge clk);
		#1;
		wb_we = 1'b0;
		@(negedge clk);
		assert (!valid && !mem_read && !mem_write && !reg_write)
			else mismatch("bubble leaves the decode register with a side effect");
	endtask

	// ====================
	// one strobed instruction
	// ====================
	task automatic run_instr(input logic [31:0] ins, input logic we,
		input logic [`MD_REG_AW-1:0] waddr, input logic [`MD_XLEN-1:0] wdata);
		logic [5:0]  op;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] sext;
		logic [31:0] e_imm;
		logic [31:0] e_jt;
		logic [6:0]  e_ctl;
		logic [4:0]  e_rd;
		logic        e_taken;
		jump_sel_t   e_jump;
		alu_op_t     e_alu;
		load_sel_t   e_ld;
		int          waits;

		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instr       = ins;
		pc4         = $urandom & 32'hffff_fffc;
		wb_we       = we;
		wb_addr     = waddr;
		wb_data     = wdata;

		// same-cycle writeback is visible to the reads
		if (we && waddr != '0)
			model_regs[waddr] = wdata;
		op      = ins[31:26];
		rs_v    = model_regs[ins[25:21]];
		rt_v    = model_regs[ins[20:16]];
		sext    = {{16{ins[15]}}, ins[15:0]};
		e_imm   = sext;
		e_alu   = ALU_RTYPE;
		e_ld    = LD_WORD;
		e_ctl   = 7'b0;
		e_jump  = JUMP_NONE;
		e_taken = 1'b0;
		e_rd    = (op == `MD_OP_JAL) ? 5'd31 : ins[15:11];

		// bits are alu_src reg_dst mem_read mem_write mem_to_reg reg_write link
		case (op)
			`MD_OP_RTYPE: begin
				e_ctl = 7'b0100010;
				if (ins[5:0] == `MD_FN_JR || ins[5:0] == `MD_FN_JALR)
					e_jump = JUMP_REG;
				if (ins[5:0] == `MD_FN_JALR)
					e_ctl[0] = 1'b1;
			end
			`MD_OP_J: e_jump = JUMP_DIRECT;
			`MD_OP_JAL: begin
				e_jump = JUMP_DIRECT;
				e_ctl  = 7'b0100011;
			end
			`MD_OP_BEQ:    e_taken = (rs_v == rt_v);
			`MD_OP_BNE:    e_taken = (rs_v != rt_v);
			`MD_OP_BLEZ:   e_taken = ($signed(rs_v) <= 0);
			`MD_OP_BGTZ:   e_taken = ($signed(rs_v) > 0);
			`MD_OP_REGIMM: e_taken = ins[16] ? ($signed(rs_v) >= 0) : ($signed(rs_v) < 0);
			`MD_OP_ADDI, `MD_OP_ADDIU, `MD_OP_SLTI, `MD_OP_SLTIU,
			`MD_OP_ANDI, `MD_OP_ORI, `MD_OP_XORI, `MD_OP_LUI: e_ctl = 7'b1000010;
			`MD_OP_LW, `MD_OP_LH, `MD_OP_LHU, `MD_OP_LB, `MD_OP_LBU: e_ctl = 7'b1010110;
			`MD_OP_SW: e_ctl = 7'b1001000;
			default: ;
		endcase

		case (op)
			`MD_OP_ADDI:  e_alu = ALU_ADDI;
			`MD_OP_ADDIU: e_alu = ALU_ADDIU;
			`MD_OP_SLTI:  e_alu = ALU_SLTI;
			`MD_OP_SLTIU: e_alu = ALU_SLTIU;
			`MD_OP_ANDI:  e_alu = ALU_ANDI;
			`MD_OP_ORI:   e_alu = ALU_ORI;
			`MD_OP_XORI:  e_alu = ALU_XORI;
			`MD_OP_LUI:   e_alu = ALU_LUI;
			`MD_OP_LW, `MD_OP_LH, `MD_OP_LHU, `MD_OP_LB, `MD_OP_LBU, `MD_OP_SW: e_alu = ALU_ADDR;
			default: ;
		endcase

		case (op)
			`MD_OP_ANDI, `MD_OP_ORI, `MD_OP_XORI, `MD_OP_LHU, `MD_OP_LBU:
				e_imm = {16'h0000, ins[15:0]};
			`MD_OP_LUI: e_imm = {ins[15:0], 16'h0000};
			default: ;
		endcase

		if (op == `MD_OP_LH || op == `MD_OP_LHU)
			e_ld = LD_HALF;
		else if (op == `MD_OP_LB || op == `MD_OP_LBU)
			e_ld = LD_BYTE;
		e_jt = (e_jump == JUMP_REG) ? rs_v : {pc4[31:28], ins[25:0], 2'b00};

		// early outputs, same cycle as the strobe
		@(negedge clk);
		assert (branch_taken === e_taken)
			else mismatch($sformatf("branch taken %b, expected %b for %h",
				branch_taken, e_taken, ins));
		assert (jump_sel === e_jump)
			else mismatch($sformatf("jump select %0d, expected %0d for %h", jump_sel, e_jump, ins));
		assert (branch_target === pc4 + {sext[29:0], 2'b00})
			else mismatch($sformatf("branch target %h wrong for %h", branch_target, ins));
		assert (e_jump == JUMP_NONE || jump_target === e_jt)
			else mismatch($sformatf("jump target %h, expected %h", jump_target, e_jt));

		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		wb_we       = 1'b0;

		waits = 0;
		@(negedge clk);
		while (!valid && waits < wait_limit) begin
			@(negedge clk);
			waits++;
		end
		if (!valid)
			stop_run("no o_valid from the decode register within the wait limit");

		// registered outputs, one clock after the strobe
		assert (rs_data === rs_v && rt_data === rt_v)
			else mismatch($sformatf("rs/rt data %h %h, expected %h %h",
				rs_data, rt_data, rs_v, rt_v));
		assert (rs_addr === ins[25:21] && rt_addr === ins[20:16] && rd_addr === e_rd)
			else mismatch($sformatf("register addresses wrong for %h", ins));
		assert (pc4_q === pc4)
			else mismatch($sformatf("pc4 %h, expected %h", pc4_q, pc4));
		assert (imm_ext === e_imm)
			else mismatch($sformatf("immediate %h, expected %h for %h", imm_ext, e_imm, ins));
		assert (alu_op === e_alu && load_sel === e_ld)
			else mismatch($sformatf("alu op %h load select %0d wrong for %h",
				alu_op, load_sel, ins));
		assert ({alu_src, reg_dst, mem_read, mem_write, mem_to_reg, reg_write, link} === e_ctl)
			else mismatch($sformatf("controls %b, expected %b for %h",
				{alu_src, reg_dst, mem_read, mem_write, mem_to_reg, reg_write, link},
				e_ctl, ins));
	endtask

	// ====================
	// stimulus
	// ====================
	initial begin
		logic [`MD_REG_AW-1:0] a;
		logic [`MD_REG_AW-1:0] b;
		logic [`MD_REG_AW-1:0] rt_f;
		logic [`MD_XLEN-1:0]   v;
		logic [`MD_XLEN-1:0]   w;
		int                    waits;

		void'($urandom(75));
		instr_valid = 1'b0;
		instr       = '0;
		pc4         = '0;
		wb_we       = 1'b0;
		wb_addr     = '0;
		wb_data     = '0;
		for (int i = 0; i < `MD_NREGS; i++)
			model_regs[i] = '0;

		// cleared while reset is held
		@(negedge clk);
		assert (!valid && !mem_read && !mem_write && !reg_write && !link && rs_data == '0
			&& rt_data == '0 && imm_ext == '0 && pc4_q == '0 && alu_op == ALU_RTYPE
			&& rs_addr == '0 && rt_addr == '0 && rd_addr == '0 && !alu_src && !reg_dst
			&& !mem_to_reg && load_sel == LD_WORD)
			else mismatch("decode register not cleared by reset");
		waits = 0;
		while (!nrst && waits < wait_limit) begin
			@(posedge clk);
			waits++;
		end
		if (!nrst)
			stop_run("reset was never released");

		// register bank, random writes then R-type reads
		for (int i = 0; i < 40; i++)
			bubble(idle_instrs[i % 4], 1'b1, 5'($urandom), $urandom);
		for (int n = 0; n < 13; n++)
			run_instr({`MD_OP_RTYPE, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom),
				r_functs[n]}, 1'b0, '0, '0);
		bubble(idle_instrs[0], 1'b1, '0, $urandom);
		run_instr({`MD_OP_RTYPE, 5'd0, 5'd0, 5'd3, 5'd0, `MD_FN_ADD}, 1'b0, '0, '0);
		a = 5'($urandom % 31 + 1);
		run_instr({`MD_OP_RTYPE, a, a, 5'd4, 5'd0, `MD_FN_OR}, 1'b1, a, $urandom);

		// immediate, load and store forms with both immediate signs
		for (int k = 0; k < 14; k++)
			for (int n = 0; n < 4; n++)
				run_instr({imm_ops[k], 5'($urandom), 5'($urandom), (n % 2 == 1),
					15'($urandom)}, 1'b0, '0, '0);
		run_instr({6'h3f, 26'($urandom)}, 1'b0, '0, '0);
		run_instr({6'h10, 26'($urandom)}, 1'b0, '0, '0);

		// branches on equal, zero, negative and random operands
		for (int k = 0; k < 6; k++) begin
			for (int n = 0; n < 4; n++) begin
				a = 5'($urandom % 31 + 1);
				b = (a == 5'd31) ? 5'd1 : a + 5'd1;
				v = (n == 1) ? 32'h0 : $urandom;
				if (n == 2)
					v[31] = 1'b1;
				w = (n == 0) ? v : $urandom;
				bubble(idle_instrs[n], 1'b1, a, v);
				bubble(idle_instrs[n], 1'b1, b, w);
				rt_f = (k < 4) ? b : ((k == 5) ? 5'd1 : 5'd0);
				run_instr({branch_ops[k], a, rt_f, 16'($urandom)}, 1'b0, '0, '0);
			end
		end

		// direct and register jumps
		run_instr({`MD_OP_J, 26'($urandom)}, 1'b0, '0, '0);
		run_instr({`MD_OP_JAL, 26'($urandom)}, 1'b0, '0, '0);
		a = 5'($urandom % 31 + 1);
		run_instr({`MD_OP_RTYPE, a, 15'd0, `MD_FN_JR}, 1'b0, '0, '0);
		run_instr({`MD_OP_RTYPE, a, 5'd0, 5'd31, 5'd0, `MD_FN_JALR}, 1'b0, '0, '0);
		// jr target through the write-through path
		run_instr({`MD_OP_RTYPE, a, 15'd0, `MD_FN_JR}, 1'b1, a, $urandom);

		@(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
